// File: sources.f
verilog/arya_pkg.sv
verilog/thread_scheduler.sv
verilog/inst_mem.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/arya_top.sv
tb/tb_clock.sv
tb/tb_arya.sv

// File: tb/tb_arya.sv
`timescale 1ns/1ps

module tb_arya import arya_pkg::*; ();

	localparam int PROG_LEN       = 16;
	localparam int EXP_DEPTH      = 8;
	localparam int TIMEOUT_CYCLES = 10 + 2 * NUM_THREADS * PROG_LEN + 2 * (RUN_CYCLES + 32) + 256;

	logic                                   clk;
	logic                                   reset;
	logic                                   en;
	logic [NUM_THREADS-1:0]                 start_thread;
	logic [IMEM_ADDR_W-1:0]                 inst_addr_in;
	logic [INST_W-1:0]                      inst_data_in;
	logic                                   setup_mem;
	logic [DATA_W-1:0]                      datamem_data_in;
	logic [INST_W-1:0]                      inst_data_out;
	logic [NUM_THREADS-1:0][DMEM_ADDR_W-1:0] datamem_addr_out;
	logic [NUM_THREADS-1:0][DATA_W-1:0]     datamem_data_out;
	logic [NUM_THREADS-1:0]                 datamem_we_out;
	thread_t                                thread_id_out;
	logic [NUM_THREADS-1:0]                 thread_busy;
	logic [NUM_THREADS-1:0]                 thread_done;

	////////////////////
	// reference state
	logic [15:0]            lfsr;
	logic [INST_W-1:0]      prog_mem [2**IMEM_ADDR_W];
	logic [DATA_W-1:0]      regs_ref [NUM_THREADS][NUM_REGS];
	logic [DATA_W-1:0]      mem_ref  [NUM_THREADS][2**DMEM_ADDR_W]; // interpreter's view
	logic [DATA_W-1:0]      dmem     [NUM_THREADS][2**DMEM_ADDR_W]; // lanes of the dut
	logic [DMEM_ADDR_W-1:0] exp_addr [NUM_THREADS][EXP_DEPTH];
	logic [DATA_W-1:0]      exp_data [NUM_THREADS][EXP_DEPTH];
	int                     exp_wr   [NUM_THREADS];
	int                     exp_rd   [NUM_THREADS];
	logic [DATA_W-1:0]      rdata_q;
	thread_t                slot_m;
	thread_t                id_hist  [4]; // slot history with the oldest last
	logic [NUM_THREADS-1:0] m_busy;
	logic [NUM_THREADS-1:0] m_done;
	int                     m_left   [NUM_THREADS];
	int                     cycles = 0;

	tb_clock i_clk (
		.clk   (clk),
		.reset (reset)
	);

	arya_top i_dut (
		.clk              (clk),
		.reset            (reset),
		.en               (en),
		.start_thread     (start_thread),
		.inst_addr_in     (inst_addr_in),
		.inst_data_in     (inst_data_in),
		.setup_mem        (setup_mem),
		.datamem_data_in  (datamem_data_in),
		.inst_data_out    (inst_data_out),
		.datamem_addr_out (datamem_addr_out),
		.datamem_data_out (datamem_data_out),
		.datamem_we_out   (datamem_we_out),
		.thread_id_out    (thread_id_out),
		.thread_busy      (thread_busy),
		.thread_done      (thread_done)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_mismatch(input string name, input logic [63:0] want,
			input logic [63:0] got);
		abort_run($sformatf("FAIL %s expected %h got %h", name, want, got));
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [INST_W-1:0] encode(input logic [3:0] op, input int rd,
			input int rs1, input int rs2, input logic [12:0] imm);
		return {op, 5'(rd), 5'(rs1), 5'(rs2), imm};
	endfunction

	function automatic logic [DATA_W-1:0] fill_word(input int t, input int a);
		logic [DATA_W-1:0] key;
		key = DATA_W'(t * 256 + a);
		return (key * 64'h9E37_79B9_7F4A_7C15) ^ (key << 40);
	endfunction

	////////////////////
	// programs and interpreter
	task automatic build_programs();
		logic [63:0]       r [6];
		logic [INST_W-1:0] w [PROG_LEN];
		for (int t = 0; t < NUM_THREADS; t++) begin
			for (int k = 0; k < 6; k++)
				take_bits(IMM_W, r[k]);
			w[0]  = encode(OP_ADDI, 1, 0, 0, r[0][12:0]);
			w[1]  = encode(OP_ADDI, 2, 0, 0, r[1][12:0]);
			w[2]  = encode(OP_ADD, 3, 1, 2, r[5][12:0]); // stray imm bits on r-type
			w[3]  = encode(OP_SUB, 4, 1, 2, r[5][12:0]);
			w[4]  = encode(OP_AND, 5, 3, 4, r[5][12:0]);
			w[5]  = encode(OP_OR, 6, 4, 1, r[5][12:0]);
			w[6]  = encode(OP_XOR, 7, 5, 6, r[5][12:0]);
			w[7]  = encode(OP_SHL, 8, 7, 0, r[2][12:0]);
			w[8]  = encode(OP_ADD, 9, 8, 3, r[5][12:0]);
			w[9]  = encode(4'hF, 9, 1, 2, r[5][12:0]);    // unused code writes nothing
			w[10] = encode(OP_STORE, 0, 2, 9, r[3][12:0]);
			w[11] = encode(OP_LOAD, 10, 2, 0, r[3][12:0]);
			w[12] = encode(OP_STORE, 0, 1, 10, r[4][12:0]);
			for (int k = 13; k < PROG_LEN; k++)
				w[k] = encode(OP_NOP, 3, 1, 2, r[5][12:0]);
			for (int pc = 0; pc < PROG_LEN; pc++)
				prog_mem[{thread_t'(t), PC_W'(pc)}] = w[pc];
		end
	endtask

	// runs one whole program and queues its stores
	task automatic interpret(input int t);
		logic [INST_W-1:0]      w;
		logic [DATA_W-1:0]      a;
		logic [DATA_W-1:0]      b;
		logic [DATA_W-1:0]      imm;
		logic [DMEM_ADDR_W-1:0] addr;
		for (int pc = 0; pc < PROG_LEN; pc++) begin
			w    = prog_mem[{thread_t'(t), PC_W'(pc)}];
			a    = regs_ref[t][w[22:18]];
			b    = regs_ref[t][w[17:13]];
			imm  = {{(DATA_W - IMM_W){w[12]}}, w[12:0]};
			addr = DMEM_ADDR_W'(a + imm);
			case (w[31:28])
				OP_ADD:  regs_ref[t][w[27:23]] = a + b;
				OP_SUB:  regs_ref[t][w[27:23]] = a - b;
				OP_AND:  regs_ref[t][w[27:23]] = a & b;
				OP_OR:   regs_ref[t][w[27:23]] = a | b;
				OP_XOR:  regs_ref[t][w[27:23]] = a ^ b;
				OP_ADDI: regs_ref[t][w[27:23]] = a + imm;
				OP_SHL:  regs_ref[t][w[27:23]] = a << imm[10:6];
				OP_LOAD: regs_ref[t][w[27:23]] = mem_ref[t][addr];
				OP_STORE: begin
					mem_ref[t][addr]          = b;
					exp_addr[t][exp_wr[t]] = addr;
					exp_data[t][exp_wr[t]] = b;
					exp_wr[t]++;
				end
				default: ;
			endcase
		end
	endtask

	task automatic program_access(input logic write, input logic [IMEM_ADDR_W-1:0] addr);
		setup_mem    = write;
		inst_addr_in = addr;
		inst_data_in = write ? prog_mem[addr] : '0;
		@(negedge clk);
		a_imem_word: assert (inst_data_out == prog_mem[addr])
			else value_mismatch("inst_data_out", prog_mem[addr], inst_data_out);
	endtask

	task automatic wait_idle();
		while (thread_busy != '0)
			@(negedge clk);
		repeat (8) @(negedge clk); // drain in-flight instructions
	endtask

	////////////////////
	// models and checks sampled on the rising edge
	always @(posedge clk) begin : monitor
		thread_t lane;
		lane = id_hist[2]; // thread in the memory stage
		if (reset) begin
			slot_m <= '0;
			m_busy <= '0;
			m_done <= '0;
			for (int i = 0; i < 4; i++)
				id_hist[i] <= '0;
		end else begin
			a_thread_id: assert (thread_id_out == id_hist[3])
				else value_mismatch("thread_id_out", id_hist[3], thread_id_out);
			a_busy: assert (thread_busy == m_busy)
				else value_mismatch("thread_busy", m_busy, thread_busy);
			a_done: assert (thread_done == m_done)
				else value_mismatch("thread_done", m_done, thread_done);
			for (int t = 0; t < NUM_THREADS; t++) begin
				a_quiet_lane: assert (t == lane || (!datamem_we_out[t]
						&& datamem_addr_out[t] == '0 && datamem_data_out[t] == '0))
					else abort_run($sformatf("lane %0d active while thread %0d is in memory",
						t, lane));
			end
			if (en) begin
				rdata_q <= dmem[lane][datamem_addr_out[lane]];
				if (datamem_we_out[lane]) begin
					a_store_expected: assert (exp_rd[lane] < exp_wr[lane])
						else abort_run($sformatf("thread %0d stored with no store pending", lane));
					a_store_addr: assert (datamem_addr_out[lane] == exp_addr[lane][exp_rd[lane]])
						else value_mismatch($sformatf("datamem_addr_out[%0d]", lane),
							exp_addr[lane][exp_rd[lane]], datamem_addr_out[lane]);
					a_store_data: assert (datamem_data_out[lane] == exp_data[lane][exp_rd[lane]])
						else value_mismatch($sformatf("datamem_data_out[%0d]", lane),
							exp_data[lane][exp_rd[lane]], datamem_data_out[lane]);
					exp_rd[lane]++;
					dmem[lane][datamem_addr_out[lane]] = datamem_data_out[lane];
				end
				slot_m     <= slot_m + 1'b1;
				id_hist[0] <= slot_m;
				id_hist[1] <= id_hist[0];
				id_hist[2] <= id_hist[1];
				id_hist[3] <= id_hist[2];
				for (int t = 0; t < NUM_THREADS; t++) begin
					m_done[t] <= 1'b0;
					if (!m_busy[t]) begin
						if (start_thread[t]) begin
							m_busy[t] <= 1'b1;
							m_left[t] <= RUN_CYCLES;
							interpret(t);
						end
					end else begin
						m_left[t] <= m_left[t] - 1;
						if (m_left[t] == 1) begin
							m_busy[t] <= 1'b0;
							m_done[t] <= 1'b1;
						end
					end
				end
			end
		end
	end

	// external memory answers a cycle after the address
	always @(negedge clk) begin
		datamem_data_in <= rdata_q;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
			abort_run($sformatf("timeout after %0d cycles", cycles));
	end

	////////////////////
	// stimulus
	initial begin : stimulus
		en              = 1'b0;
		start_thread    = '0;
		inst_addr_in    = '0;
		inst_data_in    = '0;
		setup_mem       = 1'b0;
		datamem_data_in = '0;
		rdata_q         = '0;
		lfsr            = 16'd72;
		for (int t = 0; t < NUM_THREADS; t++) begin
			exp_wr[t] = 0;
			exp_rd[t] = 0;
			m_left[t] = 0;
			for (int r = 0; r < NUM_REGS; r++)
				regs_ref[t][r] = '0;
			for (int a = 0; a < 2**DMEM_ADDR_W; a++) begin
				mem_ref[t][a] = fill_word(t, a);
				dmem[t][a]    = fill_word(t, a);
			end
		end
		build_programs();

		wait (!reset);
		@(negedge clk);
		a_idle_after_reset: assert (thread_busy == '0 && thread_done == '0)
			else abort_run("busy or done is set right after reset");
		en = 1'b1;

		for (int t = 0; t < NUM_THREADS; t++)
			for (int pc = 0; pc < PROG_LEN; pc++)
				program_access(1'b1, {thread_t'(t), PC_W'(pc)});
		for (int t = 0; t < NUM_THREADS; t++)
			for (int pc = 0; pc < PROG_LEN; pc++)
				program_access(1'b0, {thread_t'(t), PC_W'(pc)});
		setup_mem = 1'b0;

		en = 1'b0; // slot and pipeline hold
		repeat (6) @(negedge clk);
		en = 1'b1;

		// all threads together and then a start on a busy thread
		start_thread = '1;
		@(negedge clk);
		start_thread = '0;
		repeat (20) @(negedge clk);
		en = 1'b0; // hold with all four threads in flight
		repeat (3) @(negedge clk);
		en = 1'b1;
		start_thread = 4'b0100;
		@(negedge clk);
		start_thread = '0;
		wait_idle();

		for (int t = 0; t < NUM_THREADS; t++) begin
			start_thread = NUM_THREADS'(1 << t);
			@(negedge clk);
			start_thread = '0;
			repeat (2) @(negedge clk);
		end
		wait_idle();

		for (int t = 0; t < NUM_THREADS; t++) begin
			a_all_stored: assert (exp_rd[t] == exp_wr[t])
				else abort_run($sformatf("thread %0d missed %0d stores", t, exp_wr[t] - exp_rd[t]));
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: verilog/arya_top.sv
`timescale 1ns/1ps

module arya_top import arya_pkg::*; (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   en,
	input  logic [NUM_THREADS-1:0]                 start_thread,
	input  logic [IMEM_ADDR_W-1:0]                 inst_addr_in,
	input  logic [INST_W-1:0]                      inst_data_in,
	input  logic                                   setup_mem,
	input  logic [DATA_W-1:0]                      datamem_data_in,
	output logic [INST_W-1:0]                      inst_data_out,
	output logic [NUM_THREADS-1:0][DMEM_ADDR_W-1:0] datamem_addr_out,
	output logic [NUM_THREADS-1:0][DATA_W-1:0]     datamem_data_out,
	output logic [NUM_THREADS-1:0]                 datamem_we_out,
	output thread_t                                thread_id_out,
	output logic [NUM_THREADS-1:0]                 thread_busy,
	output logic [NUM_THREADS-1:0]                 thread_done
);

	fetch_t                fetch;
	logic [INST_W-1:0]     inst;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	thread_t               rd_thread;
	logic [DATA_W-1:0]     rs1_data;
	logic [DATA_W-1:0]     rs2_data;
	de_t                   de;
	em_t                   em;
	wb_t                   wb;

	////////////////////
	// front end
	thread_scheduler i_sched (
		.clk          (clk),
		.reset        (reset),
		.en           (en),
		.start_thread (start_thread),
		.fetch        (fetch),
		.thread_busy  (thread_busy),
		.thread_done  (thread_done)
	);

	inst_mem i_imem (
		.clk        (clk),
		.fetch_addr (fetch.addr),
		.fetch_data (inst),
		.prog_addr  (inst_addr_in),
		.prog_data  (inst_data_in),
		.prog_we    (setup_mem),
		.prog_rdata (inst_data_out)
	);

	regfile i_rf (
		.clk       (clk),
		.reset     (reset),
		.rd_thread (rd_thread),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.wb        (wb)
	);

	////////////////////
	// pipeline
	decode_stage i_dec (
		.clk       (clk),
		.reset     (reset),
		.en        (en),
		.fetch     (fetch),
		.inst      (inst),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd_thread (rd_thread),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.de        (de)
	);

	execute_stage i_exe (
		.clk   (clk),
		.reset (reset),
		.en    (en),
		.de    (de),
		.em    (em)
	);

	mem_wb_stage i_mwb (
		.clk              (clk),
		.reset            (reset),
		.en               (en),
		.em               (em),
		.datamem_data_in  (datamem_data_in),
		.datamem_addr_out (datamem_addr_out),
		.datamem_data_out (datamem_data_out),
		.datamem_we_out   (datamem_we_out),
		.wb               (wb),
		.thread_id_out    (thread_id_out)
	);

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import arya_pkg::*; (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   en,
	input  em_t                                    em,
	input  logic [DATA_W-1:0]                      datamem_data_in,
	output logic [NUM_THREADS-1:0][DMEM_ADDR_W-1:0] datamem_addr_out,
	output logic [NUM_THREADS-1:0][DATA_W-1:0]     datamem_data_out,
	output logic [NUM_THREADS-1:0]                 datamem_we_out,
	output wb_t                                    wb,
	output thread_t                                thread_id_out
);

	em_t mw;

	////////////////////
	// data memory lanes
	always_comb begin
		datamem_addr_out = '0;
		datamem_data_out = '0;
		datamem_we_out   = '0;
		if (em.valid) begin // only the lane of the thread in this stage
			datamem_addr_out[em.thread] = em.result[DMEM_ADDR_W-1:0];
			datamem_data_out[em.thread] = em.store_data;
			datamem_we_out[em.thread]   = em.store;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			mw <= '0;
		else if (en)
			mw <= em;
	end

	////////////////////
	// writeback
	// load data comes back from the lane a cycle after the address
	always_comb begin
		wb.enable = en && mw.we;
		wb.thread = mw.thread;
		wb.rd     = mw.rd;
		wb.data   = mw.load ? datamem_data_in : mw.result;
	end

	assign thread_id_out = mw.thread;

	a_we_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(datamem_we_out));

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import arya_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic en,
	input  de_t  de,
	output em_t  em
);

	logic [DATA_W-1:0]  alu_out;
	logic [SHAMT_W-1:0] shamt;
	logic               writes;
	em_t                em_next;

	assign shamt = de.b[SHAMT_LSB +: SHAMT_W];

	////////////////////
	// alu
	always_comb begin
		alu_out = '0;
		writes  = 1'b1;
		case (de.opcode)
			OP_ADD, OP_ADDI, OP_LOAD: alu_out = de.a + de.b;
			OP_STORE: begin
				alu_out = de.a + de.b; // address only
				writes  = 1'b0;
			end
			OP_SUB:  alu_out = de.a - de.b;
			OP_AND:  alu_out = de.a & de.b;
			OP_OR:   alu_out = de.a | de.b;
			OP_XOR:  alu_out = de.a ^ de.b;
			OP_SHL:  alu_out = de.a << shamt;
			default: writes = 1'b0; // nop and unused codes
		endcase
	end

	always_comb begin
		em_next.valid      = de.valid;
		em_next.thread     = de.thread;
		em_next.we         = de.valid && writes;
		em_next.rd         = de.rd;
		em_next.load       = de.valid && (de.opcode == OP_LOAD);
		em_next.store      = de.valid && (de.opcode == OP_STORE);
		em_next.result     = alu_out;
		em_next.store_data = de.store_data;
	end

	always_ff @(posedge clk) begin
		if (reset)
			em <= '0;
		else if (en)
			em <= em_next;
	end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import arya_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  en,
	input  fetch_t                fetch,
	input  logic [INST_W-1:0]     inst,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	output thread_t               rd_thread,
	input  logic [DATA_W-1:0]     rs1_data,
	input  logic [DATA_W-1:0]     rs2_data,
	output de_t                   de
);

	logic              fd_valid;
	thread_t           fd_thread;
	inst_t             ins;
	logic [DATA_W-1:0] imm_ext;
	logic              imm_form;
	de_t               de_next;

	// slot info one cycle late, matching the memory read
	always_ff @(posedge clk) begin
		if (reset) begin
			fd_valid  <= 1'b0;
			fd_thread <= '0;
		end else if (en) begin
			fd_valid  <= fetch.valid;
			fd_thread <= fetch.thread;
		end
	end

	////////////////////
	// fields and operands
	assign ins       = inst_t'(inst);
	assign rs1       = ins.rs1;
	assign rs2       = ins.rs2;
	assign rd_thread = fd_thread;
	assign imm_ext   = {{(DATA_W - IMM_W){ins.imm[IMM_W-1]}}, ins.imm};

	always_comb begin
		case (ins.opcode)
			OP_ADDI, OP_SHL, OP_LOAD, OP_STORE: imm_form = 1'b1;
			default:                            imm_form = 1'b0;
		endcase
	end

	always_comb begin
		de_next.valid      = fd_valid;
		de_next.thread     = fd_thread;
		de_next.opcode     = ins.opcode;
		de_next.rd         = ins.rd;
		de_next.a          = rs1_data;
		de_next.b          = imm_form ? imm_ext : rs2_data;
		de_next.store_data = rs2_data; // store source is rs2
	end

	always_ff @(posedge clk) begin
		if (reset)
			de <= '0;
		else if (en)
			de <= de_next;
	end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile import arya_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  thread_t               rd_thread,
	input  logic [REG_ADDR_W-1:0] rs1,
	input  logic [REG_ADDR_W-1:0] rs2,
	output logic [DATA_W-1:0]     rs1_data,
	output logic [DATA_W-1:0]     rs2_data,
	input  wb_t                   wb
);

	logic [DATA_W-1:0] bank [NUM_THREADS][NUM_REGS];

	// decode and writeback are never on the same thread, so no bypass
	assign rs1_data = bank[rd_thread][rs1];
	assign rs2_data = bank[rd_thread][rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				for (int r = 0; r < NUM_REGS; r++)
					bank[t][r] <= '0;
			end
		end else if (wb.enable) begin
			bank[wb.thread][wb.rd] <= wb.data;
		end
	end

endmodule

// File: verilog/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import arya_pkg::*; (
	input  logic                   clk,
	input  logic [IMEM_ADDR_W-1:0] fetch_addr,
	output logic [INST_W-1:0]      fetch_data,
	input  logic [IMEM_ADDR_W-1:0] prog_addr,
	input  logic [INST_W-1:0]      prog_data,
	input  logic                   prog_we,
	output logic [INST_W-1:0]      prog_rdata
);

	logic [INST_W-1:0] mem [2**IMEM_ADDR_W];

	// fetch port, read only
	always_ff @(posedge clk) begin
		fetch_data <= mem[fetch_addr];
	end

	// programming port, write first
	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
			prog_rdata     <= prog_data;
		end else begin
			prog_rdata <= mem[prog_addr];
		end
	end

endmodule

// File: verilog/thread_scheduler.sv
`timescale 1ns/1ps

module thread_scheduler import arya_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   en,
	input  logic [NUM_THREADS-1:0] start_thread,
	output fetch_t                 fetch,
	output logic [NUM_THREADS-1:0] thread_busy,
	output logic [NUM_THREADS-1:0] thread_done
);

	typedef enum logic {IDLE, BUSY} run_state_t;

	thread_t                slot;
	logic [PC_W-1:0]        pc_all [NUM_THREADS];
	logic [IMEM_ADDR_W-1:0] held_addr;

	// barrel slot wraps at 4
	always_ff @(posedge clk) begin
		if (reset)
			slot <= '0;
		else if (en)
			slot <= slot + 1'b1;
	end

	// last fetch address, presented again while en is low
	always_ff @(posedge clk) begin
		if (reset)
			held_addr <= '0;
		else if (en)
			held_addr <= {slot, pc_all[slot]};
	end

	////////////////////
	// per thread run control and pc
	for (genvar i = 0; i < NUM_THREADS; i++) begin : g_thread
		run_state_t           state;
		logic [RUN_CNT_W-1:0] run_cnt;
		logic                 done_q;
		logic [PC_W-1:0]      pc;
		logic                 start;
		logic                 issue;

		assign start = (state == IDLE) && start_thread[i]; // ignored while busy
		assign issue = thread_busy[i] && (slot == thread_t'(i));

		always_ff @(posedge clk) begin
			if (reset) begin
				state   <= IDLE;
				run_cnt <= '0;
				done_q  <= 1'b0;
			end else if (en) begin
				done_q <= 1'b0;
				case (state)
					IDLE: if (start) begin
						state   <= BUSY;
						run_cnt <= '0;
					end
					BUSY: begin
						run_cnt <= run_cnt + 1'b1;
						if (run_cnt == RUN_CNT_W'(RUN_CYCLES - 1)) begin
							state  <= IDLE;
							done_q <= 1'b1; // one cycle after last busy
						end
					end
					default: state <= IDLE;
				endcase
			end
		end

		always_ff @(posedge clk) begin
			if (reset)
				pc <= '0;
			else if (en) begin
				if (start)
					pc <= '0;
				else if (issue)
					pc <= pc + 1'b1;
			end
		end

		assign thread_busy[i] = (state == BUSY);
		assign thread_done[i] = done_q;
		assign pc_all[i]      = pc;

		// done only ever closes out a run
		a_done_after_busy: assert property (@(posedge clk) disable iff (reset)
			$rose(thread_done[i]) |-> $past(thread_busy[i]));
	end

	// idle threads still get their slot as a bubble
	always_comb begin
		fetch.valid  = thread_busy[slot];
		fetch.thread = slot;
		fetch.addr   = en ? {slot, pc_all[slot]} : held_addr; // word in flight stays put
	end

endmodule

// File: verilog/arya_pkg.sv
package arya_pkg;

	////////////////////
	// sizes
	localparam int THREAD_BITS = 2;
	localparam int NUM_THREADS = 2 ** THREAD_BITS;
	localparam int DATA_W      = 64;
	localparam int INST_W      = 32;
	localparam int PC_W        = 6;                  // 64 words per thread
	localparam int IMEM_ADDR_W = THREAD_BITS + PC_W; // thread index above pc
	localparam int REG_ADDR_W  = 5;
	localparam int NUM_REGS    = 2 ** REG_ADDR_W;
	localparam int DMEM_ADDR_W = 8;
	localparam int RUN_CYCLES  = 64;                 // busy cycles per start
	localparam int RUN_CNT_W   = 6;

	// instruction field widths
	localparam int OPC_W     = 4;
	localparam int IMM_W     = 13;
	localparam int SHAMT_LSB = 6; // shift amount sits in imm[10:6]
	localparam int SHAMT_W   = 5;

	typedef logic [THREAD_BITS-1:0] thread_t;

	// unlisted codes fall through as nop
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_ADDI  = 4'd6,
		OP_SHL   = 4'd7,
		OP_LOAD  = 4'd8,
		OP_STORE = 4'd9
	} opcode_t;

	////////////////////
	// instruction word, msb first
	typedef struct packed {
		opcode_t               opcode;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [IMM_W-1:0]      imm;
	} inst_t;

	////////////////////
	// stage payloads
	typedef struct packed {
		logic                   valid;
		thread_t                thread;
		logic [IMEM_ADDR_W-1:0] addr;
	} fetch_t;

	typedef struct packed {
		logic                  valid;
		thread_t               thread;
		opcode_t               opcode;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     a;
		logic [DATA_W-1:0]     b;          // rs2 or immediate
		logic [DATA_W-1:0]     store_data;
	} de_t;

	typedef struct packed {
		logic                  valid;
		thread_t               thread;
		logic                  we;
		logic [REG_ADDR_W-1:0] rd;
		logic                  load;
		logic                  store;
		logic [DATA_W-1:0]     result;     // also the data address
		logic [DATA_W-1:0]     store_data;
	} em_t;

	typedef struct packed {
		logic                  enable;
		thread_t               thread;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     data;
	} wb_t;

endpackage
